/* common/mx_fmt_pkg.sv */
`default_nettype none

package mx_fmt_pkg;

  // Mantissas that share one exponent
  localparam int BLOCK_SIZE = 4;

  // Signed input mantissa and exponent widths
  localparam int MAN_W = 8;
  localparam int EXP_W = 5;

  // Block dot product keeps full precision of BLOCK_SIZE products
  localparam int PROD_W = 2 * MAN_W + $clog2(BLOCK_SIZE);

  // Sum of two input exponents
  localparam int PEXP_W = EXP_W + 1;

  typedef logic signed [MAN_W-1:0]  man_t;
  typedef logic signed [EXP_W-1:0]  exp_t;
  typedef logic signed [PROD_W-1:0] prod_man_t;
  typedef logic signed [PEXP_W-1:0] prod_exp_t;

  // One MX integer block, 37 bits
  typedef struct packed {
    man_t [BLOCK_SIZE-1:0] man;
    exp_t                  exp;
  } mx_block_t;

  // Block dot product result, 24 bits
  typedef struct packed {
    prod_man_t man;
    prod_exp_t exp;
  } mx_prod_t;

endpackage

`default_nettype wire

/* common/mx_stream_pkg.sv */
`default_nettype none

package mx_stream_pkg;

  // Replay buffer phases
  typedef enum logic {
    LOAD   = 1'b0,
    REPLAY = 1'b1
  } buf_state_e;

  // Block beat leaving a replay buffer
  // last marks the final block of one input vector
  typedef struct packed {
    mx_fmt_pkg::mx_block_t blk;
    logic                  last;
  } blk_beat_t;

endpackage

`default_nettype wire

/* src/mx_circular.sv */
`default_nettype none

module mx_circular #(
  parameter int DEPTH   = 4,
  parameter int REPEAT  = 2,
  parameter int VEC_LEN = DEPTH
) (
  input  wire logic                     clk,
  input  wire logic                     arst_n,

  input  wire mx_fmt_pkg::mx_block_t    in_blk,
  input  wire logic                     in_valid,
  output logic                          in_ready,

  output mx_stream_pkg::blk_beat_t      out_beat,
  output logic                          out_valid,
  input  wire logic                     out_ready
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int REP_W = (REPEAT > 1) ? $clog2(REPEAT) : 1;
  localparam int SEG_W = (VEC_LEN > 1) ? $clog2(VEC_LEN) : 1;

  mx_stream_pkg::buf_state_e state;
  mx_fmt_pkg::mx_block_t     mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [REP_W-1:0] rep_cnt;
  logic [SEG_W-1:0] seg_cnt;
  logic             wr_en;
  logic             rd_en;
  logic             pass_end;

  assign in_ready  = (state == mx_stream_pkg::LOAD);
  assign out_valid = (state == mx_stream_pkg::REPLAY);
  assign wr_en     = in_valid && in_ready;
  assign rd_en     = out_valid && out_ready;
  assign pass_end  = (rd_ptr == PTR_W'(DEPTH - 1));

  assign out_beat.blk  = mem[rd_ptr];
  // End of vector, counted separately from the read pointer
  assign out_beat.last = (seg_cnt == SEG_W'(VEC_LEN - 1));

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= in_blk;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= mx_stream_pkg::LOAD;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      rep_cnt <= '0;
      seg_cnt <= '0;
    end else begin
      // Fill phase
      if (wr_en) begin
        if (wr_ptr == PTR_W'(DEPTH - 1)) begin
          wr_ptr <= '0;
          state  <= mx_stream_pkg::REPLAY;
        end else begin
          wr_ptr <= wr_ptr + 1'b1;
        end
      end

      // Replay phase, one block per output handshake
      if (rd_en) begin
        if (out_beat.last) begin
          seg_cnt <= '0;
        end else begin
          seg_cnt <= seg_cnt + 1'b1;
        end

        if (pass_end) begin
          rd_ptr <= '0;
          if (rep_cnt == REP_W'(REPEAT - 1)) begin
            rep_cnt <= '0;
            state   <= mx_stream_pkg::LOAD;
          end else begin
            rep_cnt <= rep_cnt + 1'b1;
          end
        end else begin
          rd_ptr <= rd_ptr + 1'b1;
        end
      end
    end
  end

  // Stored sequence is frozen until every pass has been sent
  a_no_write_in_replay: assert property (
    @(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  ) else $error("mx_circular: stored block changed while replaying");

endmodule

`default_nettype wire

/* mx_dot/mx_dot_product.sv */
`default_nettype none

module mx_dot_product (
  input  wire logic                     clk,
  input  wire logic                     arst_n,

  input  wire mx_stream_pkg::blk_beat_t data_beat,
  input  wire logic                     data_valid,
  output logic                          data_ready,

  input  wire mx_stream_pkg::blk_beat_t weight_beat,
  input  wire logic                     weight_valid,
  output logic                          weight_ready,

  output mx_fmt_pkg::mx_prod_t          prod,
  output logic                          prod_last,
  output logic                          prod_valid,
  input  wire logic                     prod_ready
);

  localparam int BLOCK_SIZE = mx_fmt_pkg::BLOCK_SIZE;
  localparam int MAN_W      = mx_fmt_pkg::MAN_W;
  localparam int PROD_W     = mx_fmt_pkg::PROD_W;
  localparam int PEXP_W     = mx_fmt_pkg::PEXP_W;

  logic                     slot_free;
  logic                     join_fire;
  logic signed [PROD_W-1:0] dot;
  logic signed [PEXP_W-1:0] exp_sum;

  // Join both streams into the single output slot
  assign slot_free    = !prod_valid || prod_ready;
  assign join_fire    = data_valid && weight_valid && slot_free;
  assign data_ready   = join_fire;
  assign weight_ready = join_fire;

  always_comb begin : dot_sum
    logic signed [2*MAN_W-1:0] pp;
    dot = '0;
    for (int i = 0; i < BLOCK_SIZE; i++) begin
      pp  = data_beat.blk.man[i] * weight_beat.blk.man[i];
      dot = dot + PROD_W'(pp);
    end
  end

  // Shared exponents multiply by adding
  assign exp_sum = PEXP_W'(data_beat.blk.exp) + PEXP_W'(weight_beat.blk.exp);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      prod_valid <= 1'b0;
    end else if (join_fire) begin
      prod_valid <= 1'b1;
    end else if (prod_ready) begin
      prod_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (join_fire) begin
      prod.man  <= dot;
      prod.exp  <= exp_sum;
      prod_last <= data_beat.last;
    end
  end

  // Both replay buffers must end their vectors on the same beat
  a_last_in_step: assert property (
    @(posedge clk) disable iff (!arst_n)
    join_fire |-> (data_beat.last == weight_beat.last)
  ) else $error("mx_dot_product: data and weight streams out of step");

endmodule

`default_nettype wire

/* mx_dot/mx_accumulator.sv */
`default_nettype none

module mx_accumulator #(
  parameter  int IN_DEPTH = 3,
  localparam int ACC_W    = mx_fmt_pkg::PROD_W + $clog2(IN_DEPTH)
) (
  input  wire logic                         clk,
  input  wire logic                         arst_n,

  input  wire mx_fmt_pkg::mx_prod_t         prod,
  input  wire logic                         prod_last,
  input  wire logic                         prod_valid,
  output logic                              prod_ready,

  output logic signed [ACC_W-1:0]           sum_man,
  output logic signed [mx_fmt_pkg::PEXP_W-1:0] sum_exp,
  output logic                              sum_valid,
  input  wire logic                         sum_ready
);

  localparam int PEXP_W = mx_fmt_pkg::PEXP_W;
  localparam int DIFF_W = PEXP_W + 1;
  localparam int CNT_W  = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;

  logic signed [ACC_W-1:0]  acc_man;
  logic signed [PEXP_W-1:0] acc_exp;
  logic [CNT_W-1:0]         cnt;
  logic                     in_fire;

  logic signed [ACC_W-1:0]  prod_ext;
  logic signed [ACC_W-1:0]  acc_aligned;
  logic signed [ACC_W-1:0]  prod_aligned;
  logic signed [DIFF_W-1:0] exp_diff;
  logic signed [PEXP_W-1:0] exp_max;

  // Stall upstream until the finished sum is taken
  assign prod_ready = !sum_valid;
  assign in_fire    = prod_valid && prod_ready;

  assign sum_man = acc_man;
  assign sum_exp = acc_exp;

  // Shift the operand with the smaller exponent toward the larger one
  always_comb begin
    prod_ext = ACC_W'(prod.man);
    exp_diff = DIFF_W'(acc_exp) - DIFF_W'(prod.exp);
    if (exp_diff >= 0) begin
      acc_aligned  = acc_man;
      prod_aligned = prod_ext >>> exp_diff;
      exp_max      = acc_exp;
    end else begin
      acc_aligned  = acc_man >>> (-exp_diff);
      prod_aligned = prod_ext;
      exp_max      = prod.exp;
    end
  end

  always_ff @(posedge clk) begin
    if (in_fire) begin
      if (cnt == '0) begin
        acc_man <= prod_ext;
        acc_exp <= prod.exp;
      end else begin
        acc_man <= acc_aligned + prod_aligned;
        acc_exp <= exp_max;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt       <= '0;
      sum_valid <= 1'b0;
    end else begin
      if (sum_valid && sum_ready) begin
        sum_valid <= 1'b0;
      end
      if (in_fire) begin
        if (prod_last) begin
          cnt       <= '0;
          sum_valid <= 1'b1;
        end else begin
          cnt <= cnt + 1'b1;
        end
      end
    end
  end

  // Vector end from the replay buffer lines up with the local beat count
  a_last_at_depth: assert property (
    @(posedge clk) disable iff (!arst_n)
    in_fire |-> (prod_last == (cnt == CNT_W'(IN_DEPTH - 1)))
  ) else $error("mx_accumulator: prod_last not at beat IN_DEPTH");

endmodule

`default_nettype wire

/* src/mx_cast.sv */
`default_nettype none

module mx_cast #(
  parameter int IN_MAN_W  = 20,
  parameter int OUT_MAN_W = 10
) (
  input  wire logic                                 clk,
  input  wire logic                                 arst_n,

  input  wire logic signed [IN_MAN_W-1:0]           sum_man,
  input  wire logic signed [mx_fmt_pkg::PEXP_W-1:0] sum_exp,
  input  wire logic                                 sum_valid,
  output logic                                      sum_ready,

  output logic signed [OUT_MAN_W-1:0]               out_man,
  output logic signed [mx_fmt_pkg::PEXP_W-1:0]      out_exp,
  output logic                                      out_valid,
  input  wire logic                                 out_ready
);

  localparam int PEXP_W    = mx_fmt_pkg::PEXP_W;
  localparam int MAX_SHIFT = IN_MAN_W - OUT_MAN_W;
  localparam int SH_W      = (MAX_SHIFT > 0) ? $clog2(MAX_SHIFT + 1) : 1;

  logic [SH_W-1:0]            shift;
  logic signed [IN_MAN_W-1:0] shifted;
  logic                       in_fire;

  // True when the upper bits are pure sign extension
  function automatic logic fits(input logic signed [IN_MAN_W-1:0] v);
    logic [IN_MAN_W-OUT_MAN_W:0] top;
    top = v[IN_MAN_W-1:OUT_MAN_W-1];
    return (&top) || !(|top);
  endfunction

  // Scan down so the smallest fitting shift wins
  always_comb begin
    shift = '0;
    for (int s = MAX_SHIFT; s >= 0; s--) begin
      if (fits(sum_man >>> s)) begin
        shift = SH_W'(s);
      end
    end
  end

  assign shifted   = sum_man >>> shift;
  assign sum_ready = out_ready || !out_valid;
  assign in_fire   = sum_valid && sum_ready;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else if (in_fire) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Truncating shift, exponent grows by the same amount
  always_ff @(posedge clk) begin
    if (in_fire) begin
      out_man <= shifted[OUT_MAN_W-1:0];
      out_exp <= sum_exp + PEXP_W'(shift);
    end
  end

endmodule

`default_nettype wire

/* src/mx_linear.sv */
`default_nettype none

module mx_linear #(
  parameter int IN_DEPTH     = 3,
  parameter int OUT_FEATURES = 4,
  parameter int BATCH        = 3,
  parameter int OUT_MAN_W    = 10
) (
  input  wire logic                            clk,
  input  wire logic                            arst_n,

  input  wire mx_fmt_pkg::mx_block_t           data_in,
  input  wire logic                            data_valid,
  output logic                                 data_ready,

  input  wire mx_fmt_pkg::mx_block_t           weight_in,
  input  wire logic                            weight_valid,
  output logic                                 weight_ready,

  output logic signed [OUT_MAN_W-1:0]          out_man,
  output logic signed [mx_fmt_pkg::PEXP_W-1:0] out_exp,
  output logic                                 out_valid,
  input  wire logic                            out_ready
);

  localparam int ACC_W = mx_fmt_pkg::PROD_W + $clog2(IN_DEPTH);

  mx_stream_pkg::blk_beat_t data_beat;
  logic                     data_beat_valid;
  logic                     data_beat_ready;

  mx_stream_pkg::blk_beat_t weight_beat;
  logic                     weight_beat_valid;
  logic                     weight_beat_ready;

  mx_fmt_pkg::mx_prod_t     prod;
  logic                     prod_last;
  logic                     prod_valid;
  logic                     prod_ready;

  logic signed [ACC_W-1:0]              sum_man;
  logic signed [mx_fmt_pkg::PEXP_W-1:0] sum_exp;
  logic                                 sum_valid;
  logic                                 sum_ready;

  // One input vector, replayed once per weight row
  mx_circular #(
    .DEPTH   (IN_DEPTH),
    .REPEAT  (OUT_FEATURES),
    .VEC_LEN (IN_DEPTH)
  ) u_data_buf (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_blk    (data_in),
    .in_valid  (data_valid),
    .in_ready  (data_ready),
    .out_beat  (data_beat),
    .out_valid (data_beat_valid),
    .out_ready (data_beat_ready)
  );

  // Whole weight matrix, replayed once per input vector
  mx_circular #(
    .DEPTH   (IN_DEPTH * OUT_FEATURES),
    .REPEAT  (BATCH),
    .VEC_LEN (IN_DEPTH)
  ) u_weight_buf (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_blk    (weight_in),
    .in_valid  (weight_valid),
    .in_ready  (weight_ready),
    .out_beat  (weight_beat),
    .out_valid (weight_beat_valid),
    .out_ready (weight_beat_ready)
  );

  mx_dot_product u_dot (
    .clk          (clk),
    .arst_n       (arst_n),
    .data_beat    (data_beat),
    .data_valid   (data_beat_valid),
    .data_ready   (data_beat_ready),
    .weight_beat  (weight_beat),
    .weight_valid (weight_beat_valid),
    .weight_ready (weight_beat_ready),
    .prod         (prod),
    .prod_last    (prod_last),
    .prod_valid   (prod_valid),
    .prod_ready   (prod_ready)
  );

  mx_accumulator #(
    .IN_DEPTH (IN_DEPTH)
  ) u_acc (
    .clk        (clk),
    .arst_n     (arst_n),
    .prod       (prod),
    .prod_last  (prod_last),
    .prod_valid (prod_valid),
    .prod_ready (prod_ready),
    .sum_man    (sum_man),
    .sum_exp    (sum_exp),
    .sum_valid  (sum_valid),
    .sum_ready  (sum_ready)
  );

  mx_cast #(
    .IN_MAN_W  (ACC_W),
    .OUT_MAN_W (OUT_MAN_W)
  ) u_cast (
    .clk       (clk),
    .arst_n    (arst_n),
    .sum_man   (sum_man),
    .sum_exp   (sum_exp),
    .sum_valid (sum_valid),
    .sum_ready (sum_ready),
    .out_man   (out_man),
    .out_exp   (out_exp),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

endmodule

`default_nettype wire

/* test/tb_mx_linear.sv */
`default_nettype none

module tb_mx_linear;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int IN_DEPTH     = 3;
  localparam int OUT_FEATURES = 4;
  localparam int BATCH        = 3;
  localparam int OUT_MAN_W    = 10;

  // Two weight matrices, each followed by BATCH vectors
  localparam int N_LOADS    = 2;
  localparam int N_ROW_BLKS = IN_DEPTH * OUT_FEATURES;
  localparam int N_WGT      = N_LOADS * N_ROW_BLKS;
  localparam int N_DATA     = N_LOADS * BATCH * IN_DEPTH;
  localparam int N_OUT      = N_LOADS * OUT_FEATURES * BATCH;
  localparam int TIMEOUT    = 4 * (N_WGT + N_DATA + N_OUT) + 200;

  localparam int MAN_LO = -(2 ** (OUT_MAN_W - 1));
  localparam int MAN_HI = (2 ** (OUT_MAN_W - 1)) - 1;

  logic                                 clk;
  logic                                 arst_n;
  mx_fmt_pkg::mx_block_t                data_in;
  logic                                 data_valid;
  logic                                 data_ready;
  mx_fmt_pkg::mx_block_t                weight_in;
  logic                                 weight_valid;
  logic                                 weight_ready;
  logic signed [OUT_MAN_W-1:0]          out_man;
  logic signed [mx_fmt_pkg::PEXP_W-1:0] out_exp;
  logic                                 out_valid;
  logic                                 out_ready;

  logic [15:0]           lfsr_state;
  mx_fmt_pkg::mx_block_t data_blk [N_DATA];
  mx_fmt_pkg::mx_block_t wgt_blk [N_WGT];
  int                    want_man_q[$];
  int                    want_exp_q[$];

  int data_idx  = 0;
  int wgt_idx   = 0;
  int out_cnt   = 0;
  int cycle_cnt = 0;

  // Output as seen on the previous edge
  logic                                 held_valid = 1'b0;
  logic                                 held_ready = 1'b0;
  logic signed [OUT_MAN_W-1:0]          held_man;
  logic signed [mx_fmt_pkg::PEXP_W-1:0] held_exp;

  mx_linear #(
    .IN_DEPTH     (IN_DEPTH),
    .OUT_FEATURES (OUT_FEATURES),
    .BATCH        (BATCH),
    .OUT_MAN_W    (OUT_MAN_W)
  ) i_dut (
    .clk          (clk),
    .arst_n       (arst_n),
    .data_in      (data_in),
    .data_valid   (data_valid),
    .data_ready   (data_ready),
    .weight_in    (weight_in),
    .weight_valid (weight_valid),
    .weight_ready (weight_ready),
    .out_man      (out_man),
    .out_exp      (out_exp),
    .out_valid    (out_valid),
    .out_ready    (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic lfsr_step();
    logic lsb;
    lsb        = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
      lfsr_state = lfsr_state ^ 16'hB400;
    end
    return lsb;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int k = 0; k < n; k++) begin
      v = (v << 1) | int'(lfsr_step());
    end
    return v;
  endfunction

  // One cycle in four is idle
  function automatic logic gap_drawn();
    return rand_bits(2) == 0;
  endfunction

  function automatic mx_fmt_pkg::mx_block_t random_block();
    mx_fmt_pkg::mx_block_t blk;
    logic signed [3:0]     e4;
    for (int k = 0; k < mx_fmt_pkg::BLOCK_SIZE; k++) begin
      blk.man[k] = rand_bits(mx_fmt_pkg::MAN_W);
    end
    // Narrow exponent range keeps the alignment shifts meaningful
    e4      = rand_bits(4);
    blk.exp = e4;
    return blk;
  endfunction

  function automatic int block_dot(input mx_fmt_pkg::mx_block_t a,
                                   input mx_fmt_pkg::mx_block_t b);
    logic signed [mx_fmt_pkg::MAN_W-1:0] am;
    logic signed [mx_fmt_pkg::MAN_W-1:0] bm;
    int                                  acc;
    acc = 0;
    for (int k = 0; k < mx_fmt_pkg::BLOCK_SIZE; k++) begin
      am  = a.man[k];
      bm  = b.man[k];
      acc = acc + int'(am) * int'(bm);
    end
    return acc;
  endfunction

  // Expected outputs of one vector against every row of one matrix
  function automatic void push_expected(input int mat, input int vec);
    logic signed [mx_fmt_pkg::EXP_W-1:0] xe;
    logic signed [mx_fmt_pkg::EXP_W-1:0] we;
    int acc_m;
    int acc_e;
    int p_m;
    int p_e;
    int sh;
    int didx;
    int widx;
    acc_m = 0;
    acc_e = 0;
    for (int o = 0; o < OUT_FEATURES; o++) begin
      for (int i = 0; i < IN_DEPTH; i++) begin
        didx = vec * IN_DEPTH + i;
        widx = mat * N_ROW_BLKS + o * IN_DEPTH + i;
        xe   = data_blk[didx].exp;
        we   = wgt_blk[widx].exp;
        p_m  = block_dot(data_blk[didx], wgt_blk[widx]);
        p_e  = int'(xe) + int'(we);
        if (i == 0) begin
          acc_m = p_m;
          acc_e = p_e;
        end else if (acc_e >= p_e) begin
          acc_m = acc_m + (p_m >>> (acc_e - p_e));
        end else begin
          acc_m = (acc_m >>> (p_e - acc_e)) + p_m;
          acc_e = p_e;
        end
      end
      // Smallest truncating shift that fits the output field
      sh = 0;
      while (((acc_m >>> sh) < MAN_LO) || ((acc_m >>> sh) > MAN_HI)) begin
        sh++;
      end
      want_man_q.push_back(acc_m >>> sh);
      want_exp_q.push_back(acc_e + sh);
    end
  endfunction

  function automatic void build_stimulus();
    for (int n = 0; n < N_WGT; n++) begin
      wgt_blk[n] = random_block();
    end
    for (int n = 0; n < N_DATA; n++) begin
      data_blk[n] = random_block();
    end
    for (int m = 0; m < N_LOADS; m++) begin
      for (int b = 0; b < BATCH; b++) begin
        push_expected(m, m * BATCH + b);
      end
    end
  endfunction

  // Hold a beat until taken, otherwise offer the next one or idle
  task automatic data_source();
    logic taken;
    taken = data_valid && data_ready;
    if (taken) begin
      data_idx++;
    end
    if (taken || !data_valid) begin
      if (data_idx < N_DATA && !gap_drawn()) begin
        data_valid <= 1'b1;
        data_in    <= data_blk[data_idx];
      end else begin
        data_valid <= 1'b0;
      end
    end
  endtask

  task automatic weight_source();
    logic taken;
    taken = weight_valid && weight_ready;
    if (taken) begin
      wgt_idx++;
    end
    if (taken || !weight_valid) begin
      if (wgt_idx < N_WGT && !gap_drawn()) begin
        weight_valid <= 1'b1;
        weight_in    <= wgt_blk[wgt_idx];
      end else begin
        weight_valid <= 1'b0;
      end
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT) begin
      fail_run("timeout: the expected outputs did not all arrive in time");
    end
  end

  a_reset_state: assert property (
    @(posedge clk)
    (cycle_cnt != 0 && (!arst_n || $rose(arst_n))) |->
      (!out_valid && data_ready && weight_ready)
  ) else fail_run("reset state wrong: out_valid must be low, both readies high");

  a_valid_held: assert property (
    @(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready) |=> out_valid
  ) else fail_run("out_valid dropped before the output was taken");

  always @(posedge clk) begin : check_outputs
    int want_man;
    int want_exp;
    if (arst_n) begin
      if (held_valid && !held_ready) begin
        assert (out_man == held_man) else fail_run($sformatf(
          "mismatch at %0d ns: out_man = %0d, held value %0d", $time, out_man, held_man));
        assert (out_exp == held_exp) else fail_run($sformatf(
          "mismatch at %0d ns: out_exp = %0d, held value %0d", $time, out_exp, held_exp));
      end
      if (out_valid && out_ready) begin
        assert (want_man_q.size() > 0) else fail_run("output appeared with no result expected");
        want_man = want_man_q.pop_front();
        want_exp = want_exp_q.pop_front();
        assert (int'(out_man) == want_man) else fail_run($sformatf(
          "mismatch at %0d ns: out_man = %0d, expected %0d", $time, out_man, want_man));
        assert (int'(out_exp) == want_exp) else fail_run($sformatf(
          "mismatch at %0d ns: out_exp = %0d, expected %0d", $time, out_exp, want_exp));
        out_cnt <= out_cnt + 1;
      end
    end
    held_valid <= out_valid && arst_n;
    held_ready <= out_ready;
    held_man   <= out_man;
    held_exp   <= out_exp;
  end

  initial begin : run_test
    lfsr_state   = 16'd38557;
    arst_n       = 1'b0;
    data_in      = '0;
    data_valid   = 1'b0;
    weight_in    = '0;
    weight_valid = 1'b0;
    out_ready    = 1'b0;
    build_stimulus();

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    while (data_idx < N_DATA || wgt_idx < N_WGT || out_cnt < N_OUT) begin
      @(posedge clk);
      data_source();
      weight_source();
      out_ready <= !gap_drawn();
    end

    // Nothing more may come out once the inputs are exhausted
    repeat (20) begin
      @(posedge clk);
      assert (!out_valid) else fail_run("out_valid rose after the last expected output");
    end

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
common/mx_fmt_pkg.sv
common/mx_stream_pkg.sv
src/mx_circular.sv
mx_dot/mx_dot_product.sv
mx_dot/mx_accumulator.sv
src/mx_cast.sv
src/mx_linear.sv
test/tb_mx_linear.sv

/* Bender.yml */
package:
  name: mx_linear

sources:
  - files:
      - common/mx_fmt_pkg.sv
      - common/mx_stream_pkg.sv
      - src/mx_circular.sv
      - mx_dot/mx_dot_product.sv
      - mx_dot/mx_accumulator.sv
      - src/mx_cast.sv
      - src/mx_linear.sv
  - target: test
    files:
      - test/tb_mx_linear.sv
